/* rtl/feeder_pkg.sv */
`default_nettype none

package feeder_pkg;

    // ####################################################################
    // widths with a meaning
    // ####################################################################
    typedef logic [31:0]  bus_addr_t;
    typedef logic [31:0]  bus_data_t;
    typedef logic [15:0]  word_t;
    // 32 words per line, word k at bits 16k+15 .. 16k
    typedef logic [511:0] line_t;
    typedef logic [4:0]   word_idx_t;
    typedef logic [14:0]  len_t;
    typedef logic [14:0]  sram_idx_t;
    typedef logic [7:0]   opcode_t;

    // matrix engine load opcodes
    localparam opcode_t OP_LOAD_INPUT  = 8'd9;
    localparam opcode_t OP_LOAD_WEIGHT = 8'd10;

    // register offsets from the bus base
    localparam bus_addr_t REG_DRAM_ADDR = 32'h0000_2024;
    localparam bus_addr_t REG_DRAM_LEN  = 32'h0000_2028;
    localparam bus_addr_t REG_XFER      = 32'h0000_2030;
    localparam bus_addr_t REG_SRAM_IDX  = 32'h0000_2034;
    localparam bus_addr_t REG_DATA_TYPE = 32'h0000_2038;
    localparam bus_addr_t REG_BUSY      = 32'h0000_0020;

    localparam int unsigned LINE_BYTES = 64;

    // ####################################################################
    // grouped signals
    // ####################################################################
    typedef struct packed {
        bus_addr_t addr;
        len_t      len;
        sram_idx_t sram_idx;
        logic      weight;
    } xfer_cfg_t;

    // 40 bits toward the matrix engine
    typedef struct packed {
        logic      valid;
        opcode_t   opcode;
        word_t     data;
        sram_idx_t idx;
    } load_cmd_t;

    typedef enum logic [1:0] {
        REQ_IDLE,
        REQ_WAIT,
        REQ_SEND
    } req_state_t;

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_WAIT_DATA,
        LD_ISSUE,
        LD_POP
    } load_state_t;

endpackage

`default_nettype wire

/* rtl/feeder_regs.sv */
`default_nettype none

module feeder_regs #(
    parameter feeder_pkg::bus_addr_t BUS_BASE = 32'hC400_0000
) (
    input  logic                  clk_i,
    input  logic                  rst_i,

    // host bus, host_rw_i high for a write
    input  logic                  host_strobe_i,
    input  logic                  host_rw_i,
    input  feeder_pkg::bus_addr_t host_addr_i,
    input  feeder_pkg::bus_data_t host_wdata_i,
    output logic                  host_ready_o,
    output feeder_pkg::bus_data_t host_rdata_o,

    input  logic                  req_busy_i,
    input  logic                  load_busy_i,

    output feeder_pkg::xfer_cfg_t cfg_o,
    output logic                  start_o
);

    // absolute register addresses
    localparam feeder_pkg::bus_addr_t ADDR_DRAM_ADDR = BUS_BASE + feeder_pkg::REG_DRAM_ADDR;
    localparam feeder_pkg::bus_addr_t ADDR_DRAM_LEN  = BUS_BASE + feeder_pkg::REG_DRAM_LEN;
    localparam feeder_pkg::bus_addr_t ADDR_XFER      = BUS_BASE + feeder_pkg::REG_XFER;
    localparam feeder_pkg::bus_addr_t ADDR_SRAM_IDX  = BUS_BASE + feeder_pkg::REG_SRAM_IDX;
    localparam feeder_pkg::bus_addr_t ADDR_DATA_TYPE = BUS_BASE + feeder_pkg::REG_DATA_TYPE;
    localparam feeder_pkg::bus_addr_t ADDR_BUSY      = BUS_BASE + feeder_pkg::REG_BUSY;

    logic wr_en;
    logic rd_en;
    logic busy;

    assign wr_en = host_strobe_i && host_rw_i;
    assign rd_en = host_strobe_i && !host_rw_i;

    // a start still in flight counts as busy
    assign busy = req_busy_i || load_busy_i || start_o;

    // ####################################################################
    // configuration registers
    // ####################################################################
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cfg_o <= '0;
        end else if (wr_en) begin
            case (host_addr_i)
                ADDR_DRAM_ADDR: begin
                    cfg_o.addr <= host_wdata_i;
                end
                ADDR_DRAM_LEN: begin
                    cfg_o.len <= feeder_pkg::len_t'(host_wdata_i);
                end
                ADDR_SRAM_IDX: begin
                    cfg_o.sram_idx <= feeder_pkg::sram_idx_t'(host_wdata_i);
                end
                ADDR_DATA_TYPE: begin
                    // 0 input, 1 weight
                    cfg_o.weight <= host_wdata_i[0];
                end
                default: begin
                end
            endcase
        end
    end

    // any write to the transfer register kicks both FSMs
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            start_o <= 1'b0;
        end else begin
            start_o <= wr_en && (host_addr_i == ADDR_XFER);
        end
    end

    // ####################################################################
    // bus response
    // ####################################################################
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            host_ready_o <= 1'b0;
        end else begin
            host_ready_o <= host_strobe_i;
        end
    end

    // only the busy register is readable, other reads keep the old value
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            host_rdata_o <= '0;
        end else if (rd_en && (host_addr_i == ADDR_BUSY)) begin
            host_rdata_o <= feeder_pkg::bus_data_t'(busy);
        end
    end

endmodule

`default_nettype wire

/* rtl/dram_read_req.sv */
`default_nettype none

module dram_read_req (
    input  logic                  clk_i,
    input  logic                  rst_i,

    input  logic                  start_i,
    input  feeder_pkg::xfer_cfg_t cfg_i,

    input  logic                  fifo_addr_full_i,
    input  logic                  fifo_rw_full_i,

    output logic                  dram_addr_valid_o,
    output feeder_pkg::bus_addr_t dram_addr_o,
    output logic                  busy_o
);

    feeder_pkg::req_state_t state_q;
    feeder_pkg::req_state_t state_d;

    feeder_pkg::bus_addr_t addr_q;
    feeder_pkg::len_t      covered_q;

    // bytes and words from the current address up to the line end
    logic [6:0]  span_bytes;
    logic [5:0]  span_words;
    // one bit wider so a short last line cannot wrap the count
    logic [15:0] covered_sum;
    logic        fifo_ready;

    assign span_bytes  = 7'(feeder_pkg::LINE_BYTES) - {1'b0, addr_q[5:0]};
    assign span_words  = span_bytes[6:1];
    assign covered_sum = {1'b0, covered_q} + {10'b0, span_words};
    assign fifo_ready  = !fifo_addr_full_i && !fifo_rw_full_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            feeder_pkg::REQ_IDLE: begin
                if (start_i) begin
                    state_d = feeder_pkg::REQ_WAIT;
                end
            end
            feeder_pkg::REQ_WAIT: begin
                if (fifo_ready) begin
                    state_d = feeder_pkg::REQ_SEND;
                end
            end
            feeder_pkg::REQ_SEND: begin
                if (covered_sum >= {1'b0, cfg_i.len}) begin
                    state_d = feeder_pkg::REQ_IDLE;
                end else begin
                    state_d = feeder_pkg::REQ_WAIT;
                end
            end
            default: begin
                state_d = feeder_pkg::REQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= feeder_pkg::REQ_IDLE;
            addr_q    <= '0;
            covered_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == feeder_pkg::REQ_IDLE && start_i) begin
                addr_q    <= cfg_i.addr;
                covered_q <= '0;
            end else if (state_q == feeder_pkg::REQ_SEND) begin
                // jump to the next 64-byte boundary
                addr_q    <= addr_q + feeder_pkg::bus_addr_t'(span_bytes);
                covered_q <= feeder_pkg::len_t'(covered_sum);
            end
        end
    end

    assign dram_addr_valid_o = (state_q == feeder_pkg::REQ_SEND);
    assign dram_addr_o       = addr_q;
    assign busy_o            = (state_q != feeder_pkg::REQ_IDLE);

endmodule

`default_nettype wire

/* rtl/gemm_load_feeder.sv */
`default_nettype none

module gemm_load_feeder (
    input  logic                  clk_i,
    input  logic                  rst_i,

    input  logic                  start_i,
    input  feeder_pkg::xfer_cfg_t cfg_i,

    // show-ahead data FIFO from the memory side
    input  logic                  fifo_data_empty_i,
    input  feeder_pkg::line_t     dram_line_i,

    output logic                  fifo_data_rd_en_o,
    output feeder_pkg::load_cmd_t load_cmd_o,
    output logic                  busy_o
);

    feeder_pkg::load_state_t state_q;
    feeder_pkg::load_state_t state_d;

    feeder_pkg::line_t     line_q;
    feeder_pkg::word_idx_t word_ptr_q;
    feeder_pkg::len_t      sent_q;
    feeder_pkg::sram_idx_t sram_idx_q;
    feeder_pkg::load_cmd_t cmd_q;

    feeder_pkg::word_t     cur_word;
    logic                  last_in_line;
    logic                  last_in_xfer;
    logic                  issuing;

    assign cur_word     = line_q[{word_ptr_q, 4'b0000} +: 16];
    assign last_in_line = (word_ptr_q == 5'd31);
    assign last_in_xfer = (feeder_pkg::len_t'(sent_q + 1'b1) == cfg_i.len);
    assign issuing      = (state_q == feeder_pkg::LD_ISSUE);

    // ####################################################################
    // FSM
    // ####################################################################
    always_comb begin
        state_d = state_q;
        case (state_q)
            feeder_pkg::LD_IDLE: begin
                if (start_i) begin
                    state_d = feeder_pkg::LD_WAIT_DATA;
                end
            end
            feeder_pkg::LD_WAIT_DATA: begin
                if (!fifo_data_empty_i) begin
                    state_d = feeder_pkg::LD_ISSUE;
                end
            end
            feeder_pkg::LD_ISSUE: begin
                if (last_in_line || last_in_xfer) begin
                    state_d = feeder_pkg::LD_POP;
                end
            end
            feeder_pkg::LD_POP: begin
                if (sent_q >= cfg_i.len) begin
                    state_d = feeder_pkg::LD_IDLE;
                end else begin
                    state_d = feeder_pkg::LD_WAIT_DATA;
                end
            end
            default: begin
                state_d = feeder_pkg::LD_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= feeder_pkg::LD_IDLE;
            word_ptr_q <= '0;
            sent_q     <= '0;
            sram_idx_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == feeder_pkg::LD_IDLE && start_i) begin
                // first line may start mid-line
                word_ptr_q <= cfg_i.addr[5:1];
                sent_q     <= '0;
                sram_idx_q <= cfg_i.sram_idx;
            end else if (issuing) begin
                // pointer wraps to 0 for the next line
                word_ptr_q <= word_ptr_q + 1'b1;
                sent_q     <= sent_q + 1'b1;
                sram_idx_q <= sram_idx_q + 1'b1;
            end
        end
    end

    // line capture
    always_ff @(posedge clk_i) begin
        if (state_q == feeder_pkg::LD_WAIT_DATA && !fifo_data_empty_i) begin
            line_q <= dram_line_i;
        end
    end

    // ####################################################################
    // command output
    // ####################################################################
    always_ff @(posedge clk_i) begin
        cmd_q.opcode <= cfg_i.weight ? feeder_pkg::OP_LOAD_WEIGHT
                                     : feeder_pkg::OP_LOAD_INPUT;
        cmd_q.data   <= cur_word;
        cmd_q.idx    <= sram_idx_q;
        if (rst_i) begin
            cmd_q.valid <= 1'b0;
        end else begin
            cmd_q.valid <= issuing;
        end
    end

    assign load_cmd_o        = cmd_q;
    assign fifo_data_rd_en_o = (state_q == feeder_pkg::LD_POP);
    assign busy_o            = (state_q != feeder_pkg::LD_IDLE);

endmodule

`default_nettype wire

/* rtl/data_feeder_top.sv */
`default_nettype none

module data_feeder_top #(
    parameter feeder_pkg::bus_addr_t BUS_BASE = 32'hC400_0000
) (
    input  logic                  clk_i,
    input  logic                  rst_i,

    // host bus
    input  logic                  host_strobe_i,
    input  logic                  host_rw_i,
    input  feeder_pkg::bus_addr_t host_addr_i,
    input  feeder_pkg::bus_data_t host_wdata_i,
    output logic                  host_ready_o,
    output feeder_pkg::bus_data_t host_rdata_o,

    // memory request and data FIFOs
    input  logic                  fifo_addr_full_i,
    input  logic                  fifo_rw_full_i,
    input  logic                  fifo_data_empty_i,
    input  feeder_pkg::line_t     dram_line_i,
    output logic                  dram_addr_valid_o,
    output feeder_pkg::bus_addr_t dram_addr_o,
    output logic                  fifo_data_rd_en_o,

    // toward the matrix engine
    output feeder_pkg::load_cmd_t load_cmd_o
);

    feeder_pkg::xfer_cfg_t xfer_cfg;
    logic                  xfer_start;
    logic                  req_busy;
    logic                  load_busy;

    feeder_regs #(
        .BUS_BASE (BUS_BASE)
    ) feeder_regs_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .host_strobe_i (host_strobe_i),
        .host_rw_i     (host_rw_i),
        .host_addr_i   (host_addr_i),
        .host_wdata_i  (host_wdata_i),
        .host_ready_o  (host_ready_o),
        .host_rdata_o  (host_rdata_o),
        .req_busy_i    (req_busy),
        .load_busy_i   (load_busy),
        .cfg_o         (xfer_cfg),
        .start_o       (xfer_start)
    );

    dram_read_req dram_read_req_inst (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .start_i           (xfer_start),
        .cfg_i             (xfer_cfg),
        .fifo_addr_full_i  (fifo_addr_full_i),
        .fifo_rw_full_i    (fifo_rw_full_i),
        .dram_addr_valid_o (dram_addr_valid_o),
        .dram_addr_o       (dram_addr_o),
        .busy_o            (req_busy)
    );

    gemm_load_feeder gemm_load_feeder_inst (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .start_i           (xfer_start),
        .cfg_i             (xfer_cfg),
        .fifo_data_empty_i (fifo_data_empty_i),
        .dram_line_i       (dram_line_i),
        .fifo_data_rd_en_o (fifo_data_rd_en_o),
        .load_cmd_o        (load_cmd_o),
        .busy_o            (load_busy)
    );

endmodule

`default_nettype wire

/* tb/data_feeder_checker.sv */
`default_nettype none

module data_feeder_checker (
    input logic clk_i,
    input logic rst_i,
    input logic host_strobe_i,
    input logic host_ready_i,
    input logic dram_addr_valid_i,
    input logic fifo_addr_full_i,
    input logic fifo_data_rd_en_i
);

    // ######################################################################
    // handshake properties
    // ######################################################################

    // bus answers exactly one cycle after the strobe
    ready_after_strobe: assert property (
        @(posedge clk_i) disable iff (rst_i) host_strobe_i |=> host_ready_i
    ) else $error("host ready did not follow a strobe one cycle later");

    // a request is only sent after a cycle with room in the address FIFO
    no_send_into_full: assert property (
        @(posedge clk_i) disable iff (rst_i) dram_addr_valid_i |-> !$past(fifo_addr_full_i)
    ) else $error("read request sent right after the address FIFO was full");

    // single-cycle pop per line
    single_pop: assert property (
        @(posedge clk_i) disable iff (rst_i) fifo_data_rd_en_i |=> !fifo_data_rd_en_i
    ) else $error("data FIFO read enable held high for two cycles");

endmodule

`default_nettype wire

/* tb/data_feeder_tb.sv */
`default_nettype none

module data_feeder_tb;

    localparam int unsigned           NUM_XFERS = 12;
    localparam feeder_pkg::bus_addr_t BUS_BASE  = 32'hC400_0000;

    logic                  clk_i;
    logic                  rst_i;
    logic                  host_strobe_i;
    logic                  host_rw_i;
    feeder_pkg::bus_addr_t host_addr_i;
    feeder_pkg::bus_data_t host_wdata_i;
    logic                  host_ready_o;
    feeder_pkg::bus_data_t host_rdata_o;
    logic                  fifo_addr_full_i;
    logic                  fifo_rw_full_i;
    logic                  fifo_data_empty_i;
    feeder_pkg::line_t     dram_line_i;
    logic                  dram_addr_valid_o;
    feeder_pkg::bus_addr_t dram_addr_o;
    logic                  fifo_data_rd_en_o;
    feeder_pkg::load_cmd_t load_cmd_o;

    // five words per transfer holding address, length, weight, sram index and stall
    logic [31:0] patterns [0:5*NUM_XFERS-1];

    integer                seed;
    int unsigned           cycle_count;
    int unsigned           cycle_limit;
    feeder_pkg::line_t     lines_q [$];
    feeder_pkg::line_t     pending_q [$];

    // current transfer and its expected progress
    feeder_pkg::bus_addr_t cur_addr;
    feeder_pkg::len_t      cur_len;
    logic                  cur_weight;
    feeder_pkg::sram_idx_t cur_sram;
    int unsigned           cur_stall;
    int unsigned           line_base;
    feeder_pkg::bus_addr_t exp_req_addr;
    int unsigned           req_count;
    int unsigned           pop_count;
    int unsigned           cmd_count;

    // FIFO model control
    logic                  arm_stall;
    logic                  pop_flag;
    logic                  req_full_prev;
    int unsigned           req_stall;
    int unsigned           data_stall;

    data_feeder_top #(
        .BUS_BASE (BUS_BASE)
    ) data_feeder_top_inst (.*);

    bind data_feeder_top data_feeder_checker data_feeder_checker_inst (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .host_strobe_i     (host_strobe_i),
        .host_ready_i      (host_ready_o),
        .dram_addr_valid_i (dram_addr_valid_o),
        .fifo_addr_full_i  (fifo_addr_full_i),
        .fifo_data_rd_en_i (fifo_data_rd_en_o)
    );

    always #5 clk_i = ~clk_i;

    task automatic check_value(input string what, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Error at time %0t: %s is %0h, expected %0h",
                     $time, what, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    // one host access with ready expected one cycle after the strobe
    task automatic bus_access(input logic write, input feeder_pkg::bus_addr_t offset,
                              input feeder_pkg::bus_data_t wdata,
                              output feeder_pkg::bus_data_t rdata);
        @(posedge clk_i);
        #1;
        host_strobe_i = 1'b1;
        host_rw_i     = write;
        host_addr_i   = BUS_BASE + offset;
        host_wdata_i  = wdata;
        check_value("host_ready_o", host_ready_o, 0);
        @(posedge clk_i);
        #1;
        host_strobe_i = 1'b0;
        check_value("host_ready_o", host_ready_o, 1);
        rdata = host_rdata_o;
    endtask

    task automatic make_line(output feeder_pkg::line_t line);
        for (int i = 0; i < 16; i++) begin
            line[i*32 +: 32] = $random(seed);
        end
    endtask

    // ######################################################################
    // monitor sampled mid-cycle
    // ######################################################################
    always @(negedge clk_i) begin
        feeder_pkg::line_t line;
        int unsigned       pos;
        if (!rst_i) begin
            if (arm_stall) begin
                req_stall  = cur_stall;
                data_stall = cur_stall;
                arm_stall  = 1'b0;
            end
            if (dram_addr_valid_o) begin
                check_value("dram_addr_o", dram_addr_o, exp_req_addr);
                check_value("FIFO full before request", req_full_prev, 0);
                exp_req_addr = (exp_req_addr & ~32'h3F) + 32'h40;
                make_line(line);
                lines_q.push_back(line);
                pending_q.push_back(line);
                req_count++;
                req_stall = cur_stall;
            end
            if (fifo_data_rd_en_o) begin
                pop_flag = 1'b1;
                pop_count++;
                data_stall = cur_stall;
            end
            if (load_cmd_o.valid) begin
                // word position counted from the start of the first line
                pos  = cur_addr[5:1] + cmd_count;
                line = lines_q[line_base + pos / 32];
                check_value("load_cmd_o.data", load_cmd_o.data, line[(pos % 32) * 16 +: 16]);
                check_value("load_cmd_o.opcode", load_cmd_o.opcode,
                            cur_weight ? feeder_pkg::OP_LOAD_WEIGHT : feeder_pkg::OP_LOAD_INPUT);
                check_value("load_cmd_o.idx", load_cmd_o.idx,
                            feeder_pkg::sram_idx_t'(cur_sram + cmd_count));
                cmd_count++;
            end
        end
    end

    // request and show-ahead data FIFO models
    always @(posedge clk_i) begin
        #1;
        // full state of the cycle that just ended
        req_full_prev = fifo_addr_full_i || fifo_rw_full_i;
        if (pop_flag) begin
            void'(pending_q.pop_front());
            pop_flag = 1'b0;
        end
        // address FIFO full early in a stall and the read/write FIFO in its last cycle
        fifo_addr_full_i  = (req_stall > 1);
        fifo_rw_full_i    = (req_stall == 1);
        fifo_data_empty_i = (pending_q.size() == 0) || (data_stall > 0);
        dram_line_i       = fifo_data_empty_i ? '0 : pending_q[0];
        if (req_stall > 0) begin
            req_stall--;
        end
        if (data_stall > 0) begin
            data_stall--;
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: transfers not finished after %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    task automatic run_transfer(input int unsigned t);
        feeder_pkg::bus_data_t rdata;
        int unsigned           lines;
        cur_addr     = patterns[5*t];
        cur_len      = feeder_pkg::len_t'(patterns[5*t+1]);
        cur_weight   = patterns[5*t+2][0];
        cur_sram     = feeder_pkg::sram_idx_t'(patterns[5*t+3]);
        cur_stall    = patterns[5*t+4];
        lines        = (cur_addr[5:1] + cur_len + 31) / 32;
        line_base    = lines_q.size();
        exp_req_addr = cur_addr;
        req_count    = 0;
        pop_count    = 0;
        cmd_count    = 0;
        bus_access(1'b1, feeder_pkg::REG_DRAM_ADDR, cur_addr, rdata);
        bus_access(1'b1, feeder_pkg::REG_DRAM_LEN, 32'(cur_len), rdata);
        bus_access(1'b1, feeder_pkg::REG_SRAM_IDX, 32'(cur_sram), rdata);
        bus_access(1'b1, feeder_pkg::REG_DATA_TYPE, 32'(cur_weight), rdata);
        bus_access(1'b1, feeder_pkg::REG_XFER, 32'd1, rdata);
        arm_stall = 1'b1;
        bus_access(1'b0, feeder_pkg::REG_BUSY, '0, rdata);
        check_value("busy after start", rdata, 1);
        do begin
            bus_access(1'b0, feeder_pkg::REG_BUSY, '0, rdata);
        end while (rdata != 0);
        check_value("read request count", req_count, lines);
        check_value("data FIFO pop count", pop_count, lines);
        check_value("load command count", cmd_count, cur_len);
    endtask

    // ######################################################################
    // main sequence
    // ######################################################################
    initial begin
        feeder_pkg::bus_data_t rdata;
        int unsigned           lines;
        seed              = 32'h9ca43956;
        clk_i             = 1'b0;
        rst_i             = 1'b1;
        host_strobe_i     = 1'b0;
        host_rw_i         = 1'b0;
        host_addr_i       = '0;
        host_wdata_i      = '0;
        fifo_addr_full_i  = 1'b0;
        fifo_rw_full_i    = 1'b0;
        fifo_data_empty_i = 1'b1;
        dram_line_i       = '0;
        arm_stall         = 1'b0;
        pop_flag          = 1'b0;
        req_full_prev     = 1'b0;
        req_stall         = 0;
        data_stall        = 0;
        cur_stall         = 0;
        cycle_count       = 0;
        $readmemh("tb/data_feeder_patterns.hex", patterns);
        // lengths, stalls and per-line overhead with margin
        cycle_limit = 0;
        for (int t = 0; t < NUM_XFERS; t++) begin
            lines = (patterns[5*t][5:1] + patterns[5*t+1] + 31) / 32;
            cycle_limit += patterns[5*t+1] + 2 * patterns[5*t+4] * lines + 16 * lines + 40;
        end
        cycle_limit = cycle_limit * 4;
        repeat (2) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        check_value("host_ready_o", host_ready_o, 0);
        check_value("dram_addr_valid_o", dram_addr_valid_o, 0);
        check_value("fifo_data_rd_en_o", fifo_data_rd_en_o, 0);
        check_value("load_cmd_o.valid", load_cmd_o.valid, 0);
        bus_access(1'b0, feeder_pkg::REG_BUSY, '0, rdata);
        check_value("busy after reset", rdata, 0);
        for (int t = 0; t < NUM_XFERS; t++) begin
            run_transfer(t);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/data_feeder_patterns.hex */
// columns: dram byte address, length in words, weight select, sram start index,
// stall cycles applied to the request and data FIFOs
80000000 0020 0 0000 00
80000040 0040 1 0100 00
80000012 0010 0 0200 00
8000003E 0002 1 0010 00
80001008 0050 0 1000 03
80002020 0030 1 0040 05
8000407C 0005 1 0123 04
80005000 0080 0 0400 00
80005100 0003 1 7FFF 06
8000603A 0060 0 0800 02
80007FC0 0041 0 0033 01
80008010 00C8 0 1234 02

/* compile.f */
rtl/feeder_pkg.sv
rtl/feeder_regs.sv
rtl/dram_read_req.sv
rtl/gemm_load_feeder.sv
rtl/data_feeder_top.sv
tb/data_feeder_checker.sv
tb/data_feeder_tb.sv

/* Bender.yml */
package:
  name: data_feeder

sources:
  - files:
      - rtl/feeder_pkg.sv
      - rtl/feeder_regs.sv
      - rtl/dram_read_req.sv
      - rtl/gemm_load_feeder.sv
      - rtl/data_feeder_top.sv
  - target: test
    files:
      - tb/data_feeder_checker.sv
      - tb/data_feeder_tb.sv
